// File: filelist.f
hdl/csr_pkg.sv
hdl/csr_file.sv
hdl/csr_op_unit.sv
hdl/trap_ctrl.sv
hdl/csr_unit_top.sv
testbench/tb_csr_unit.sv

// File: Makefile
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
RTL_TOP   ?= csr_unit_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
RTL_SRCS  ?= hdl/csr_pkg.sv hdl/csr_file.sv hdl/csr_op_unit.sv \
             hdl/trap_ctrl.sv hdl/csr_unit_top.sv
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timescale 1ns/1ns --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_csr_unit.sv
// CSR unit testbench with clock, reset, compare tasks, directed tests and summary
`timescale 1ns/1ns

module tb_csr_unit import csr_pkg::*; ();

  logic      clk;
  logic      rst;
  csr_req_t  csr_req;
  csr_resp_t csr_resp;
  trap_req_t trap_req;
  retire_t   retire;
  logic      irq_msip, irq_mtip, irq_meip;
  redirect_t redirect;

  logic [31:0] rng_state;
  int          test_errors, total_errors, tests_run, tests_failed;

  csr_unit_top DUT (
    .clk      (clk),
    .rst      (rst),
    .csr_req  (csr_req),
    .csr_resp (csr_resp),
    .trap_req (trap_req),
    .retire   (retire),
    .irq_msip (irq_msip),
    .irq_mtip (irq_mtip),
    .irq_meip (irq_meip),
    .redirect (redirect)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_word(output xlen_t w);
    logic [31:0] hi;
    hi = xorshift(rng_state);
    rng_state = xorshift(hi);
    w = {hi, rng_state};
  endtask

  // Trap entry moves MIE into MPIE, clears MIE and sets MPP to machine
  function automatic xlen_t entry_status(input xlen_t old);
    xlen_t s;
    s = old;
    s[7] = old[3];
    s[3] = 1'b0;
    s[12:11] = 2'b11;
    return s;
  endfunction

  function automatic xlen_t mret_status(input xlen_t old);
    xlen_t s;
    s = old;
    s[3] = old[7];
    s[7] = 1'b1;
    return s;
  endfunction

  // Standard codes with MEI over MSI over MTI
  function automatic xlen_t irq_winner(input xlen_t pending);
    if (pending[11]) return 64'd11;
    if (pending[3]) return 64'd3;
    return 64'd7;
  endfunction

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_redirect(input string name, input redirect_t got, input redirect_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %b/%h expected %b/%h", $time, name,
               got.valid, got.target, exp.valid, exp.target);
      test_errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // Issues one instruction and samples the response mid-cycle
  task automatic csr_access(input csr_op_e op, input csr_addr_t addr, input xlen_t src,
                            output xlen_t rdata, output logic illegal);
    csr_req.valid = 1'b1;
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.src   = src;
    #2;
    check_flag("csr_resp.valid", csr_resp.valid, 1'b1);
    rdata   = csr_resp.rdata;
    illegal = csr_resp.illegal;
    next_cycle();
    csr_req.valid = 1'b0;
  endtask

  task automatic read_csr(input csr_addr_t addr, output xlen_t value);
    logic illegal;
    csr_access(csr_rs, addr, '0, value, illegal);
    check_flag($sformatf("read %h illegal", addr), illegal, 1'b0);
  endtask

  task automatic expect_csr(input string name, input csr_addr_t addr, input xlen_t exp);
    xlen_t value;
    read_csr(addr, value);
    check_word(name, value, exp);
  endtask

  task automatic write_csr(input csr_addr_t addr, input xlen_t value);
    xlen_t old;
    logic  illegal;
    csr_access(csr_rw, addr, value, old, illegal);
    check_flag($sformatf("write %h illegal", addr), illegal, 1'b0);
  endtask

  task automatic wait_redirect(input redirect_t exp);
    int cycles;
    cycles = 0;
    while (!redirect.valid && cycles < 20) begin
      next_cycle();
      cycles++;
    end
    if (!redirect.valid) begin
      $display("Timeout at %0t ns: no redirect within 20 cycles", $time);
      test_errors++;
    end else begin
      check_flag("redirect one cycle after event", cycles == 0, 1'b1);
      check_redirect("redirect", redirect, exp);
      next_cycle();
      check_flag("redirect single pulse", redirect.valid, 1'b0);
    end
  endtask

  // Retire window held open while no interrupt may be taken
  task automatic hold_retire(input string name, input int n);
    retire.valid = 1'b1;
    next_word(retire.pc);
    repeat (n) begin
      next_cycle();
      check_flag(name, redirect.valid, 1'b0);
    end
    retire.valid = 1'b0;
    next_cycle();
    check_flag(name, redirect.valid, 1'b0);
  endtask

  task automatic test_reset_values();
    csr_addr_t zero_regs [10] = '{addr_mie, addr_mtvec, addr_mscratch, addr_mepc,
                                  addr_mcause, addr_mtval, addr_mvendorid,
                                  addr_marchid, addr_mimpid, addr_mhartid};
    check_flag("redirect.valid after reset", redirect.valid, 1'b0);
    expect_csr("mstatus reset", addr_mstatus, mstatus_reset);
    expect_csr("misa", addr_misa, misa_value);
    foreach (zero_regs[i]) expect_csr($sformatf("csr %h reset", zero_regs[i]), zero_regs[i], '0);
    finish_test("reset_values");
  endtask

  // Runs rw, rs, rc and a zero-mask rs against a model of the register
  task automatic rmw_sequence(input string name, input csr_addr_t addr, input xlen_t wmask);
    xlen_t   model, src, old;
    logic    illegal;
    csr_op_e op;
    read_csr(addr, model);
    for (int i = 0; i < 4; i++) begin
      case (i)
        0:       op = csr_rw;
        2:       op = csr_rc;
        default: op = csr_rs;
      endcase
      if (i == 3) src = '0;
      else next_word(src);
      csr_access(op, addr, src, old, illegal);
      check_flag($sformatf("%s %s illegal", name, op.name()), illegal, 1'b0);
      check_word($sformatf("%s %s old value", name, op.name()), old, model);
      case (op)
        csr_rw:  model = src & wmask;
        csr_rs:  model = (model | src) & wmask;
        default: model = model & ~src;
      endcase
      expect_csr($sformatf("%s after %s", name, op.name()), addr, model);
    end
  endtask

  task automatic test_read_modify_write();
    xlen_t first, second;
    rmw_sequence("mscratch", addr_mscratch, '1);
    rmw_sequence("mtvec", addr_mtvec, ~64'h2);  // Bit 1 of mtvec is hardwired low
    read_csr(addr_mcycle, first);
    repeat (5) next_cycle();
    read_csr(addr_mcycle, second);
    check_word("mcycle six cycles later", second, first + 64'd6);
    finish_test("read_modify_write");
  endtask

  task automatic test_illegal_access();
    xlen_t src, old;
    logic  illegal;
    next_word(src);
    csr_access(csr_rw, 12'h7c0, src, old, illegal);
    check_flag("unknown address illegal", illegal, 1'b1);
    csr_access(csr_rw, addr_mhartid, src, old, illegal);
    check_flag("mhartid write illegal", illegal, 1'b1);
    csr_access(csr_rs, addr_misa, src, old, illegal);
    check_flag("misa write illegal", illegal, 1'b1);
    expect_csr("mhartid after write", addr_mhartid, '0);
    expect_csr("misa after write", addr_misa, misa_value);
    finish_test("illegal_access");
  endtask

  task automatic test_exception();
    xlen_t     tvec, old_status, scratch, epc, tval, rdata;
    logic      illegal;
    redirect_t exp;
    tvec = 64'h0000_0000_8000_1000;
    write_csr(addr_mtvec, tvec);
    csr_access(csr_rc, addr_mstatus, 64'h1800, rdata, illegal);  // MPP to user first
    csr_access(csr_rs, addr_mstatus, 64'h8, rdata, illegal);     // MIE on
    read_csr(addr_mstatus, old_status);
    read_csr(addr_mscratch, scratch);
    next_word(epc);
    epc[1:0] = 2'b00;
    next_word(tval);
    trap_req.valid = 1'b1;
    trap_req.mret  = 1'b0;
    trap_req.cause = 64'd2;
    trap_req.epc   = epc;
    trap_req.tval  = tval;
    csr_req.valid  = 1'b1;  // Competing write that loses to the exception
    csr_req.op     = csr_rw;
    csr_req.addr   = addr_mscratch;
    csr_req.src    = ~scratch;
    #2;
    check_word("blocked write read data", csr_resp.rdata, scratch);
    next_cycle();
    trap_req.valid = 1'b0;
    csr_req.valid  = 1'b0;
    exp.valid  = 1'b1;
    exp.target = tvec & ~64'h3;
    wait_redirect(exp);
    expect_csr("mepc after exception", addr_mepc, epc);
    expect_csr("mcause after exception", addr_mcause, 64'd2);
    expect_csr("mtval after exception", addr_mtval, tval);
    expect_csr("mstatus after exception", addr_mstatus, entry_status(old_status));
    expect_csr("mscratch after blocked write", addr_mscratch, scratch);
    finish_test("exception_entry");
  endtask

  task automatic test_mret();
    xlen_t     old_status, epc, rdata;
    logic      illegal;
    redirect_t exp;
    csr_access(csr_rc, addr_mstatus, 64'h80, rdata, illegal);  // MPIE off
    csr_access(csr_rs, addr_mstatus, 64'h8, rdata, illegal);   // MIE on
    read_csr(addr_mstatus, old_status);
    read_csr(addr_mepc, epc);
    trap_req.valid = 1'b1;
    trap_req.mret  = 1'b1;
    next_cycle();
    trap_req.valid = 1'b0;
    trap_req.mret  = 1'b0;
    exp.valid  = 1'b1;
    exp.target = epc;
    wait_redirect(exp);
    expect_csr("mstatus after mret", addr_mstatus, mret_status(old_status));
    finish_test("mret");
  endtask

  task automatic test_interrupts();
    xlen_t     base, pc, rdata, pending, code, old_status;
    logic      illegal;
    redirect_t exp;
    csr_access(csr_rc, addr_mstatus, 64'h8, rdata, illegal);  // MIE off
    base = 64'h0000_0000_0000_2000;
    write_csr(addr_mtvec, base | 64'h1);  // Vectored
    write_csr(addr_mie, 64'h888);
    irq_msip = 1'b1;
    irq_mtip = 1'b1;
    irq_meip = 1'b1;
    expect_csr("mip before the edge", addr_mip, '0);
    pending = 64'h888;
    expect_csr("mip follows lines", addr_mip, pending);
    hold_retire("no redirect with MIE clear", 4);
    write_csr(addr_mie, '0);
    csr_access(csr_rs, addr_mstatus, 64'h8, rdata, illegal);
    hold_retire("no redirect with mie clear", 4);
    write_csr(addr_mie, 64'h888);
    read_csr(addr_mstatus, old_status);
    next_word(pc);
    pc[1:0] = 2'b00;
    retire.valid = 1'b1;
    retire.pc    = pc;
    next_cycle();
    retire.valid = 1'b0;
    code = irq_winner(pending);
    exp.valid  = 1'b1;
    exp.target = base + (code << 2);
    wait_redirect(exp);
    expect_csr("mcause after interrupt", addr_mcause, {1'b1, 63'd0} | code);
    expect_csr("mepc after interrupt", addr_mepc, pc);
    expect_csr("mtval after interrupt", addr_mtval, '0);
    expect_csr("mstatus after interrupt", addr_mstatus, entry_status(old_status));
    irq_msip = 1'b0;
    irq_mtip = 1'b0;
    irq_meip = 1'b0;
    finish_test("interrupts");
  endtask

  initial begin
    rng_state    = 32'h6769;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst      = 1'b1;
    csr_req  = '0;
    trap_req = '0;
    retire   = '0;
    irq_msip = 1'b0;
    irq_mtip = 1'b0;
    irq_meip = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_values();
    test_read_modify_write();
    test_illegal_access();
    test_exception();
    test_mret();
    test_interrupts();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/csr_unit_top.sv
// CSR subsystem top joining the instruction unit, trap controller and CSR file
`timescale 1ns/1ns

module csr_unit_top import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_req_t  csr_req,
  output csr_resp_t csr_resp,
  input  trap_req_t trap_req,
  input  retire_t   retire,
  input  logic      irq_msip,
  input  logic      irq_mtip,
  input  logic      irq_meip,
  output redirect_t redirect
);

  csr_addr_t rd_addr;
  xlen_t     rd_data;
  logic      rd_illegal;
  logic      wr_en;
  csr_addr_t wr_addr;
  xlen_t     wr_data;
  logic      block_wr;

  logic      trap_we;
  logic      mret_we;
  xlen_t     mstatus_next, mepc_next, mcause_next, mtval_next;
  xlen_t     mstatus, mie, mip, mtvec, mepc;

  csr_op_unit u_csr_op_unit (
    .csr_req    (csr_req),
    .csr_resp   (csr_resp),
    .block_wr   (block_wr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_illegal (rd_illegal),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  trap_ctrl u_trap_ctrl (
    .clk          (clk),
    .rst          (rst),
    .trap_req     (trap_req),
    .retire       (retire),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .trap_we      (trap_we),
    .mret_we      (mret_we),
    .mstatus_next (mstatus_next),
    .mepc_next    (mepc_next),
    .mcause_next  (mcause_next),
    .mtval_next   (mtval_next),
    .block_wr     (block_wr),
    .redirect     (redirect)
  );

  csr_file u_csr_file (
    .clk          (clk),
    .rst          (rst),
    .irq_msip     (irq_msip),
    .irq_mtip     (irq_mtip),
    .irq_meip     (irq_meip),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_illegal   (rd_illegal),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .trap_we      (trap_we),
    .mret_we      (mret_we),
    .mstatus_next (mstatus_next),
    .mepc_next    (mepc_next),
    .mcause_next  (mcause_next),
    .mtval_next   (mtval_next),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

endmodule

// File: hdl/trap_ctrl.sv
// Exception, mret and interrupt sequencing with trap CSR values and registered redirect
`timescale 1ns/1ns

module trap_ctrl import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  trap_req_t trap_req,
  input  retire_t   retire,

  // Current CSR state
  input  xlen_t     mstatus,
  input  xlen_t     mie,
  input  xlen_t     mip,
  input  xlen_t     mtvec,
  input  xlen_t     mepc,

  // CSR file update
  output logic      trap_we,
  output logic      mret_we,
  output xlen_t     mstatus_next,
  output xlen_t     mepc_next,
  output xlen_t     mcause_next,
  output xlen_t     mtval_next,

  output logic      block_wr,
  output redirect_t redirect
);

  trap_state_e state, state_next;
  xlen_t       target_d;
  xlen_t       target_q;
  xlen_t       irq_pend;
  xlen_t       irq_code;
  xlen_t       tvec_base;
  logic        take_exc;
  logic        take_mret;
  logic        take_irq;
  logic        event_any;

  assign irq_pend = mie & mip;

  assign take_exc  = trap_req.valid && !trap_req.mret;
  assign take_mret = trap_req.valid && trap_req.mret;
  assign take_irq  = retire.valid && !trap_req.valid &&
                     mstatus[mstatus_mie_bit] && (irq_pend != '0);
  assign event_any = trap_req.valid || take_irq;

  // Fixed priority MEI > MSI > MTI with codes equal to the mip bit positions
  always_comb begin
    if (irq_pend[mip_meip_bit]) begin
      irq_code = xlen_t'(mip_meip_bit);
    end else if (irq_pend[mip_msip_bit]) begin
      irq_code = xlen_t'(mip_msip_bit);
    end else begin
      irq_code = xlen_t'(mip_mtip_bit);
    end
  end

  always_comb begin
    mstatus_next = mstatus;
    if (take_mret) begin
      mstatus_next[mstatus_mie_bit]  = mstatus[mstatus_mpie_bit];
      mstatus_next[mstatus_mpie_bit] = 1'b1;
    end else begin
      // Trap entry stacks MIE and stays in machine mode
      mstatus_next[mstatus_mpie_bit] = mstatus[mstatus_mie_bit];
      mstatus_next[mstatus_mie_bit]  = 1'b0;
      mstatus_next[mstatus_mpp_hi:mstatus_mpp_lo] = 2'b11;
    end
  end

  assign trap_we  = take_exc || take_irq;
  assign mret_we  = take_mret;
  assign block_wr = event_any;  // CSR instruction write has lowest priority

  assign mepc_next   = take_exc ? trap_req.epc : retire.pc;
  assign mcause_next = take_exc ? trap_req.cause : (irq_cause_flag | irq_code);
  assign mtval_next  = take_exc ? trap_req.tval : '0;

  assign tvec_base = {mtvec[63:2], 2'b00};

  always_comb begin
    if (take_mret) begin
      target_d = mepc;
    end else if (take_irq && mtvec[0]) begin
      target_d = tvec_base + (irq_code << 2);  // Vectored mode
    end else begin
      target_d = tvec_base;
    end
  end

  // Redirect state follows each accepted event for one cycle
  assign state_next = event_any ? trap_redirect : trap_idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= trap_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (event_any) target_q <= target_d;
  end

  assign redirect.valid  = (state == trap_redirect);
  assign redirect.target = target_q;

endmodule

// File: hdl/csr_op_unit.sv
// CSRRW / CSRRS / CSRRC read-modify-write and illegal access check
`timescale 1ns/1ns

module csr_op_unit import csr_pkg::*; (
  input  csr_req_t  csr_req,
  output csr_resp_t csr_resp,
  input  logic      block_wr,   // Trap or interrupt owns this cycle

  // CSR file read port
  output csr_addr_t rd_addr,
  input  xlen_t     rd_data,
  input  logic      rd_illegal,

  // CSR file write port
  output logic      wr_en,
  output csr_addr_t wr_addr,
  output xlen_t     wr_data
);

  xlen_t new_val;
  logic  writes_reg;
  logic  read_only;
  logic  illegal;

  assign rd_addr = csr_req.addr;

  always_comb begin
    case (csr_req.op)
      csr_rs:  new_val = rd_data | csr_req.src;
      csr_rc:  new_val = rd_data & ~csr_req.src;
      default: new_val = csr_req.src;
    endcase
  end

  // Set and clear with a zero mask are pure reads
  assign writes_reg = (csr_req.op == csr_rw) || (csr_req.src != '0);

  // Top two address bits 11 mark read-only and misa is fixed in this core
  assign read_only = (&csr_req.addr[11:10]) || (csr_req.addr == addr_misa);

  assign illegal = rd_illegal || (writes_reg && read_only);

  assign csr_resp.valid   = csr_req.valid;
  assign csr_resp.illegal = csr_req.valid && illegal;
  assign csr_resp.rdata   = rd_data;     // Old value even when the write is blocked

  assign wr_en   = csr_req.valid && !illegal && !block_wr && writes_reg;
  assign wr_addr = csr_req.addr;
  assign wr_data = new_val;

endmodule

// File: hdl/csr_file.sv
// Machine CSR storage, one-hot read multiplexer, address decode and mcycle counter
`timescale 1ns/1ns

module csr_file import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // External interrupt lines
  input  logic      irq_msip,
  input  logic      irq_mtip,
  input  logic      irq_meip,

  // Combinational read port
  input  csr_addr_t rd_addr,
  output xlen_t     rd_data,
  output logic      rd_illegal,

  // Software write port that takes effect on the next edge
  input  logic      wr_en,
  input  csr_addr_t wr_addr,
  input  xlen_t     wr_data,

  // Trap update paths
  input  logic      trap_we,
  input  logic      mret_we,
  input  xlen_t     mstatus_next,
  input  xlen_t     mepc_next,
  input  xlen_t     mcause_next,
  input  xlen_t     mtval_next,

  output xlen_t     mstatus,
  output xlen_t     mie,
  output xlen_t     mip,
  output xlen_t     mtvec,
  output xlen_t     mepc
);

  xlen_t mscratch;
  xlen_t mcause;
  xlen_t mtval;
  xlen_t mcycle;

  // Read address decode
  logic sel_mstatus, sel_misa, sel_mie, sel_mtvec, sel_mscratch;
  logic sel_mepc, sel_mcause, sel_mtval, sel_mip, sel_mcycle;
  logic sel_ident;

  assign sel_mstatus  = (rd_addr == addr_mstatus);
  assign sel_misa     = (rd_addr == addr_misa);
  assign sel_mie      = (rd_addr == addr_mie);
  assign sel_mtvec    = (rd_addr == addr_mtvec);
  assign sel_mscratch = (rd_addr == addr_mscratch);
  assign sel_mepc     = (rd_addr == addr_mepc);
  assign sel_mcause   = (rd_addr == addr_mcause);
  assign sel_mtval    = (rd_addr == addr_mtval);
  assign sel_mip      = (rd_addr == addr_mip);
  assign sel_mcycle   = (rd_addr == addr_mcycle);

  // Vendor, arch, impl and hart IDs all read as zero
  assign sel_ident = (rd_addr == addr_mvendorid) || (rd_addr == addr_marchid) ||
                     (rd_addr == addr_mimpid)    || (rd_addr == addr_mhartid);

  assign rd_illegal = !(sel_mstatus || sel_misa  || sel_mie    || sel_mtvec ||
                        sel_mscratch || sel_mepc || sel_mcause || sel_mtval ||
                        sel_mip      || sel_mcycle || sel_ident);

  assign rd_data = ({64{sel_mstatus}}  & mstatus)
                 | ({64{sel_misa}}     & misa_value)
                 | ({64{sel_mie}}      & mie)
                 | ({64{sel_mtvec}}    & mtvec)
                 | ({64{sel_mscratch}} & mscratch)
                 | ({64{sel_mepc}}     & mepc)
                 | ({64{sel_mcause}}   & mcause)
                 | ({64{sel_mtval}}    & mtval)
                 | ({64{sel_mip}}      & mip)
                 | ({64{sel_mcycle}}   & mcycle);

  // Write strobes
  logic wr_mstatus, wr_mie, wr_mtvec, wr_mscratch;
  logic wr_mepc, wr_mcause, wr_mtval, wr_mcycle;

  assign wr_mstatus  = wr_en && (wr_addr == addr_mstatus);
  assign wr_mie      = wr_en && (wr_addr == addr_mie);
  assign wr_mtvec    = wr_en && (wr_addr == addr_mtvec);
  assign wr_mscratch = wr_en && (wr_addr == addr_mscratch);
  assign wr_mepc     = wr_en && (wr_addr == addr_mepc);
  assign wr_mcause   = wr_en && (wr_addr == addr_mcause);
  assign wr_mtval    = wr_en && (wr_addr == addr_mtval);
  assign wr_mcycle   = wr_en && (wr_addr == addr_mcycle);

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= mstatus_reset;
    end else if (trap_we || mret_we) begin  // Trap paths win over software
      mstatus <= mstatus_next;
    end else if (wr_mstatus) begin
      mstatus <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
    end else begin
      if (wr_mie) mie <= wr_data;
      if (wr_mtvec) mtvec <= {wr_data[63:2], 1'b0, wr_data[0]}; // Modes 0 and 1 only
      if (wr_mscratch) mscratch <= wr_data;
    end
  end

  // mepc, mcause and mtval load together on trap entry
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap_we) begin
      mepc   <= mepc_next;
      mcause <= mcause_next;
      mtval  <= mtval_next;
    end else begin
      if (wr_mepc) mepc <= wr_data;
      if (wr_mcause) mcause <= wr_data;
      if (wr_mtval) mtval <= wr_data;
    end
  end

  // Pending bits track the lines and ignore software writes
  always_ff @(posedge clk) begin
    if (rst) begin
      mip <= '0;
    end else begin
      mip               <= '0;
      mip[mip_msip_bit] <= irq_msip;
      mip[mip_mtip_bit] <= irq_mtip;
      mip[mip_meip_bit] <= irq_meip;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else if (wr_mcycle) begin
      mcycle <= wr_data;
    end else begin
      mcycle <= mcycle + 64'd1;
    end
  end

endmodule

// File: hdl/csr_pkg.sv
// Shared CSR word types, address map, reset values, port structs and trap FSM states
package csr_pkg;

  typedef logic [63:0] xlen_t;     // Machine word
  typedef logic [11:0] csr_addr_t; // CSR address

  // Instruction kinds after decode with immediate forms already resolved
  typedef enum logic [1:0] {
    csr_rw = 2'd0,
    csr_rs = 2'd1,
    csr_rc = 2'd2
  } csr_op_e;

  // Machine CSR address map
  localparam csr_addr_t addr_mstatus   = 12'h300;
  localparam csr_addr_t addr_misa      = 12'h301;
  localparam csr_addr_t addr_mie       = 12'h304;
  localparam csr_addr_t addr_mtvec     = 12'h305;
  localparam csr_addr_t addr_mscratch  = 12'h340;
  localparam csr_addr_t addr_mepc      = 12'h341;
  localparam csr_addr_t addr_mcause    = 12'h342;
  localparam csr_addr_t addr_mtval     = 12'h343;
  localparam csr_addr_t addr_mip       = 12'h344;
  localparam csr_addr_t addr_mcycle    = 12'hb00;
  localparam csr_addr_t addr_mvendorid = 12'hf11;
  localparam csr_addr_t addr_marchid   = 12'hf12;
  localparam csr_addr_t addr_mimpid    = 12'hf13;
  localparam csr_addr_t addr_mhartid   = 12'hf14;

  localparam xlen_t misa_value    = 64'h8000_0000_0000_0100; // MXL=2 with the I extension
  localparam xlen_t mstatus_reset = 64'h0000_0000_0000_1800; // MPP = machine

  // mstatus fields
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_hi   = 12;
  localparam int mstatus_mpp_lo   = 11;

  // mip and mie bits double as the interrupt cause codes
  localparam int mip_msip_bit = 3;
  localparam int mip_mtip_bit = 7;
  localparam int mip_meip_bit = 11;

  localparam xlen_t irq_cause_flag = 64'h8000_0000_0000_0000;

  // CSR instruction from the decoder
  typedef struct packed {
    logic      valid;
    csr_op_e   op;
    csr_addr_t addr;
    xlen_t     src;   // rs1 value
  } csr_req_t;

  typedef struct packed {
    logic  valid;
    logic  illegal;
    xlen_t rdata;     // Value before the write
  } csr_resp_t;

  // Exception or mret from the pipeline
  typedef struct packed {
    logic  valid;
    logic  mret;
    xlen_t cause;
    xlen_t epc;
    xlen_t tval;
  } trap_req_t;

  // Retiring instruction that opens the window for an interrupt
  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } retire_t;

  typedef struct packed {
    logic  valid;
    xlen_t target;
  } redirect_t;

  typedef enum logic {
    trap_idle     = 1'b0,
    trap_redirect = 1'b1
  } trap_state_e;

endpackage
